// ==== common/mask_cfg_pkg.sv ====
package mask_cfg_pkg;

  // vector register width in bits
  localparam int VLEN = 128;

  // vl and vstart width
  localparam int VL_WIDTH = 8;

  localparam int ROB_IDX_WIDTH = 3;

  // result buffer entries
  localparam int FIFO_DEPTH = 4;

  // results the ROB takes before credit must come back
  localparam int ROB_CREDITS = 2;

  // bits per first-level popcount adder
  localparam int POP_GROUP = 16;

  typedef logic [VLEN-1:0] vreg_t;

  typedef logic [VL_WIDTH-1:0] vl_t;

  typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;

  // holds 0 to FIFO_DEPTH
  typedef logic [$clog2(FIFO_DEPTH+1)-1:0] credit_t;

endpackage

// ==== common/mask_op_pkg.sv ====
package mask_op_pkg;

  typedef logic [2:0] funct3_t;
  typedef logic [5:0] funct6_t;
  typedef logic [4:0] vs1_op_t;

  localparam funct3_t OPMVV = 3'b010;

  // mask logical ops
  localparam funct6_t VMANDN = 6'b011000;
  localparam funct6_t VMAND  = 6'b011001;
  localparam funct6_t VMOR   = 6'b011010;
  localparam funct6_t VMXOR  = 6'b011011;
  localparam funct6_t VMORN  = 6'b011100;
  localparam funct6_t VMNAND = 6'b011101;
  localparam funct6_t VMNOR  = 6'b011110;
  localparam funct6_t VMXNOR = 6'b011111;

  // unary groups, sub-op in vs1
  localparam funct6_t VWXUNARY0 = 6'b010000;
  localparam funct6_t VMUNARY0  = 6'b010100;

  localparam vs1_op_t VCPOP  = 5'b10000;
  localparam vs1_op_t VFIRST = 5'b10001;
  localparam vs1_op_t VMSBF  = 5'b00001;
  localparam vs1_op_t VMSOF  = 5'b00010;
  localparam vs1_op_t VMSIF  = 5'b00011;

  typedef enum logic [3:0] {
    MOP_NONE, MOP_AND, MOP_NAND, MOP_ANDN, MOP_XOR, MOP_OR, MOP_NOR, MOP_ORN,
    MOP_XNOR, MOP_CPOP, MOP_FIRST, MOP_SBF, MOP_SIF, MOP_SOF
  } mask_op_e;

endpackage

// ==== exec/mask_find_first.sv ====
`timescale 1ns/10ps

module mask_find_first (
  input  mask_cfg_pkg::vreg_t src,
  output mask_cfg_pkg::vreg_t first_onehot,
  output mask_cfg_pkg::vreg_t before_first,
  output mask_cfg_pkg::vreg_t upto_first,
  output mask_cfg_pkg::vreg_t first_index,
  output logic                none_set
);
  import mask_cfg_pkg::*;

  localparam int IDX_W = $clog2(VLEN);

  vreg_t             lowest;
  logic [IDX_W-1:0]  idx;

  // two's complement trick isolates the lowest set bit
  assign lowest   = src & (~src + 1'b1);
  assign none_set = src == '0;

  // both wrap to all ones on a zero source
  assign before_first = lowest - 1'b1;
  assign upto_first   = before_first | lowest;
  assign first_onehot = none_set ? '1 : lowest;

  // one-hot to binary
  always_comb begin
    idx = '0;
    for (int i = 0; i < VLEN; i++) begin
      if (lowest[i]) begin
        idx = idx | IDX_W'(i);
      end
    end
  end

  assign first_index = none_set ? '1 : {{(VLEN-IDX_W){1'b0}}, idx};

endmodule

// ==== exec/mask_popcount.sv ====
`timescale 1ns/10ps

module mask_popcount (
  input  mask_cfg_pkg::vreg_t src,
  output mask_cfg_pkg::vreg_t count
);
  import mask_cfg_pkg::*;

  localparam int GROUPS = VLEN / POP_GROUP;
  localparam int GW     = $clog2(POP_GROUP + 1);
  localparam int CW     = $clog2(VLEN + 1);

  logic [GROUPS-1:0][POP_GROUP-1:0][GW-1:0] node;
  logic [CW-1:0]                            total;

  // pairwise reduction per group, sum lands in node[g][0]
  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int i = 0; i < POP_GROUP; i++) begin
        node[g][i] = GW'(src[g*POP_GROUP + i]);
      end
      for (int span = 1; span < POP_GROUP; span = span * 2) begin
        for (int i = 0; i < POP_GROUP; i += 2 * span) begin
          node[g][i] = node[g][i] + node[g][i+span];
        end
      end
    end
  end

  always_comb begin
    total = '0;
    for (int g = 0; g < GROUPS; g++) begin
      total = total + CW'(node[g][0]);
    end
  end

  assign count = {{(VLEN-CW){1'b0}}, total};

endmodule

// ==== src/mask_issue.sv ====
`timescale 1ns/10ps

module mask_issue (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  output logic                    uop_ready,
  input  mask_cfg_pkg::rob_idx_t  rob_entry,
  input  mask_op_pkg::funct3_t    funct3,
  input  mask_op_pkg::funct6_t    funct6,
  input  mask_op_pkg::vs1_op_t    vs1_op,
  input  logic                    vm,
  input  mask_cfg_pkg::vl_t       vstart,
  input  mask_cfg_pkg::vl_t       vl,
  input  mask_cfg_pkg::vreg_t     v0_data,
  input  mask_cfg_pkg::vreg_t     vd_data,
  input  mask_cfg_pkg::vreg_t     vs1_data,
  input  mask_cfg_pkg::vreg_t     vs2_data,
  input  logic                    buf_credit,
  output logic                    push,
  output mask_cfg_pkg::rob_idx_t  push_rob_entry,
  output mask_cfg_pkg::vreg_t     push_data
);
  import mask_cfg_pkg::*;
  import mask_op_pkg::*;

  mask_op_e op;
  credit_t  credits;
  vreg_t    tail_mask;
  vreg_t    body_mask;
  vreg_t    src;
  vreg_t    logic_res;
  vreg_t    merge_sel;
  vreg_t    pop_count;
  vreg_t    ff_onehot;
  vreg_t    ff_before;
  vreg_t    ff_upto;
  vreg_t    ff_index;

  always_comb begin
    op = MOP_NONE;
    if (funct3 == OPMVV) begin
      case (funct6)
        VMAND:  op = MOP_AND;
        VMNAND: op = MOP_NAND;
        VMANDN: op = MOP_ANDN;
        VMXOR:  op = MOP_XOR;
        VMOR:   op = MOP_OR;
        VMNOR:  op = MOP_NOR;
        VMORN:  op = MOP_ORN;
        VMXNOR: op = MOP_XNOR;
        VWXUNARY0: begin
          if (vs1_op == VCPOP) begin
            op = MOP_CPOP;
          end else if (vs1_op == VFIRST) begin
            op = MOP_FIRST;
          end
        end
        VMUNARY0: begin
          case (vs1_op)
            VMSBF:   op = MOP_SBF;
            VMSIF:   op = MOP_SIF;
            VMSOF:   op = MOP_SOF;
            default: op = MOP_NONE;
          endcase
        end
        default: op = MOP_NONE;
      endcase
    end
  end

  // tail = bits below vl, body = bits at or above vstart
  always_comb begin
    for (int j = 0; j < VLEN; j++) begin
      tail_mask[j] = j < vl;
      body_mask[j] = j >= vstart;
    end
  end

  assign src       = vs2_data & tail_mask & (vm ? '1 : v0_data);
  assign merge_sel = vm ? '0 : (tail_mask & ~v0_data);

  mask_find_first u_find_first (
    .src          (src),
    .first_onehot (ff_onehot),
    .before_first (ff_before),
    .upto_first   (ff_upto),
    .first_index  (ff_index),
    .none_set     ()
  );

  mask_popcount u_popcount (
    .src   (src),
    .count (pop_count)
  );

  always_comb begin
    case (op)
      MOP_AND:  logic_res = vs2_data & vs1_data;
      MOP_NAND: logic_res = ~(vs2_data & vs1_data);
      MOP_ANDN: logic_res = vs2_data & ~vs1_data;
      MOP_XOR:  logic_res = vs2_data ^ vs1_data;
      MOP_OR:   logic_res = vs2_data | vs1_data;
      MOP_NOR:  logic_res = ~(vs2_data | vs1_data);
      MOP_ORN:  logic_res = vs2_data | ~vs1_data;
      MOP_XNOR: logic_res = ~(vs2_data ^ vs1_data);
      default:  logic_res = '0;
    endcase
  end

  always_comb begin
    case (op)
      MOP_CPOP:  push_data = pop_count;
      MOP_FIRST: push_data = ff_index;
      MOP_SBF:   push_data = (ff_before & ~merge_sel) | (vd_data & merge_sel);
      MOP_SIF:   push_data = (ff_upto & ~merge_sel) | (vd_data & merge_sel);
      MOP_SOF:   push_data = (ff_onehot & ~merge_sel) | (vd_data & merge_sel);
      MOP_NONE:  push_data = '0;
      // prestart elements keep vd
      default:   push_data = (logic_res & body_mask) | (vd_data & ~body_mask);
    endcase
  end

  assign uop_ready      = credits != '0;
  assign push           = uop_valid && uop_ready;
  assign push_rob_entry = rob_entry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= credit_t'(FIFO_DEPTH);
    end else if (push && !buf_credit) begin
      credits <= credits - 1'b1;
    end else if (!push && buf_credit) begin
      credits <= credits + 1'b1;
    end
  end

  a_known_op: assert property (@(posedge clk) disable iff (!rst_n) push |-> op != MOP_NONE);

  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n) credits <= FIFO_DEPTH);

endmodule

// ==== src/mask_result_fifo.sv ====
`timescale 1ns/10ps

module mask_result_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,
  input  mask_cfg_pkg::rob_idx_t  push_rob_entry,
  input  mask_cfg_pkg::vreg_t     push_data,
  input  logic                    pop,
  output logic                    not_empty,
  output mask_cfg_pkg::rob_idx_t  head_rob_entry,
  output mask_cfg_pkg::vreg_t     head_data,
  output logic                    buf_credit
);
  import mask_cfg_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  rob_idx_t          rob_mem [FIFO_DEPTH];
  vreg_t             data_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  credit_t           count;

  always_ff @(posedge clk) begin
    if (push) begin
      rob_mem[wr_ptr]  <= push_rob_entry;
      data_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      buf_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
      // freed slot goes back to issue
      buf_credit <= pop;
    end
  end

  assign not_empty      = count != '0;
  assign head_rob_entry = rob_mem[rd_ptr];
  assign head_data      = data_mem[rd_ptr];

  // issue credits must keep the queue from overflowing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count != credit_t'(FIFO_DEPTH)) || pop);

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

// ==== src/mask_rob_sender.sv ====
`timescale 1ns/10ps

module mask_rob_sender (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    not_empty,
  input  mask_cfg_pkg::rob_idx_t  head_rob_entry,
  input  mask_cfg_pkg::vreg_t     head_data,
  output logic                    pop,
  input  logic                    rob_credit,
  output logic                    result_valid,
  output mask_cfg_pkg::rob_idx_t  result_rob_entry,
  output mask_cfg_pkg::vreg_t     result_data
);
  import mask_cfg_pkg::*;

  localparam int CW = $clog2(ROB_CREDITS + 1);

  logic [CW-1:0] credits;

  // a result in the output register has not been charged yet
  assign pop = not_empty && (credits > result_valid);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      credits      <= CW'(ROB_CREDITS);
    end else begin
      result_valid <= pop;
      if (result_valid && !rob_credit) begin
        credits <= credits - 1'b1;
      end else if (!result_valid && rob_credit) begin
        credits <= credits + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      result_rob_entry <= head_rob_entry;
      result_data      <= head_data;
    end
  end

  a_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> credits != '0);

endmodule

// ==== src/mask_alu_top.sv ====
`timescale 1ns/10ps

module mask_alu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    uop_valid,
  output logic                    uop_ready,
  input  mask_cfg_pkg::rob_idx_t  rob_entry,
  input  mask_op_pkg::funct3_t    funct3,
  input  mask_op_pkg::funct6_t    funct6,
  input  mask_op_pkg::vs1_op_t    vs1_op,
  input  logic                    vm,
  input  mask_cfg_pkg::vl_t       vstart,
  input  mask_cfg_pkg::vl_t       vl,
  input  mask_cfg_pkg::vreg_t     v0_data,
  input  mask_cfg_pkg::vreg_t     vd_data,
  input  mask_cfg_pkg::vreg_t     vs1_data,
  input  mask_cfg_pkg::vreg_t     vs2_data,
  input  logic                    rob_credit,
  output logic                    result_valid,
  output mask_cfg_pkg::rob_idx_t  result_rob_entry,
  output mask_cfg_pkg::vreg_t     result_data
);
  import mask_cfg_pkg::*;

  logic     push;
  rob_idx_t push_rob_entry;
  vreg_t    push_data;
  logic     buf_credit;
  logic     pop;
  logic     not_empty;
  rob_idx_t head_rob_entry;
  vreg_t    head_data;

  mask_issue u_issue (
    .clk            (clk),
    .rst_n          (rst_n),
    .uop_valid      (uop_valid),
    .uop_ready      (uop_ready),
    .rob_entry      (rob_entry),
    .funct3         (funct3),
    .funct6         (funct6),
    .vs1_op         (vs1_op),
    .vm             (vm),
    .vstart         (vstart),
    .vl             (vl),
    .v0_data        (v0_data),
    .vd_data        (vd_data),
    .vs1_data       (vs1_data),
    .vs2_data       (vs2_data),
    .buf_credit     (buf_credit),
    .push           (push),
    .push_rob_entry (push_rob_entry),
    .push_data      (push_data)
  );

  mask_result_fifo u_fifo (
    .clk            (clk),
    .rst_n          (rst_n),
    .push           (push),
    .push_rob_entry (push_rob_entry),
    .push_data      (push_data),
    .pop            (pop),
    .not_empty      (not_empty),
    .head_rob_entry (head_rob_entry),
    .head_data      (head_data),
    .buf_credit     (buf_credit)
  );

  mask_rob_sender u_sender (
    .clk              (clk),
    .rst_n            (rst_n),
    .not_empty        (not_empty),
    .head_rob_entry   (head_rob_entry),
    .head_data        (head_data),
    .pop              (pop),
    .rob_credit       (rob_credit),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

// ==== tests/tb_mask_alu.sv ====
`timescale 1ns/10ps

module tb_mask_alu;
  import mask_cfg_pkg::*;
  import mask_op_pkg::*;

  localparam int CLK_NS         = 40;
  localparam int NUM_UOPS       = 49;
  localparam int CYCLES_PER_UOP = 12;
  localparam int MARGIN_CYCLES  = 200;
  localparam int WATCHDOG_CYCLES = NUM_UOPS * CYCLES_PER_UOP + MARGIN_CYCLES;
  localparam int READY_TIMEOUT  = 50;
  localparam int DRAIN_TIMEOUT  = 100;
  localparam int BP_IDLE_LIMIT  = 8;

  logic     clk;
  logic     rst_n;
  logic     uop_valid;
  logic     uop_ready;
  rob_idx_t rob_entry;
  funct3_t  funct3;
  funct6_t  funct6;
  vs1_op_t  vs1_op;
  logic     vm;
  vl_t      vstart;
  vl_t      vl;
  vreg_t    v0_data;
  vreg_t    vd_data;
  vreg_t    vs1_data;
  vreg_t    vs2_data;
  logic     rob_credit = 1'b0;
  logic     result_valid;
  rob_idx_t result_rob_entry;
  vreg_t    result_data;

  // expected results in issue order
  vreg_t    exp_data_q[$];
  rob_idx_t exp_rob_q[$];

  int       errors = 0;
  int       checks = 0;
  int       tests_run = 0;
  int       tests_failed = 0;
  int       received = 0;
  int       pending_credits = 0;
  logic     hold_credit = 1'b0;
  rob_idx_t next_rob = '0;

  mask_alu_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (uop_valid),
    .uop_ready        (uop_ready),
    .rob_entry        (rob_entry),
    .funct3           (funct3),
    .funct6           (funct6),
    .vs1_op           (vs1_op),
    .vm               (vm),
    .vstart           (vstart),
    .vl               (vl),
    .v0_data          (v0_data),
    .vd_data          (vd_data),
    .vs1_data         (vs1_data),
    .vs2_data         (vs2_data),
    .rob_credit       (rob_credit),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic compare(string name, vreg_t expected, vreg_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // ROB model, one credit back per result unless held
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("at %0t ns a result arrived with no uop outstanding", $time);
      end else begin
        compare("result_rob_entry", VLEN'(exp_rob_q.pop_front()), VLEN'(result_rob_entry));
        compare("result_data", exp_data_q.pop_front(), result_data);
      end
      received++;
      pending_credits++;
    end
    if (pending_credits > 0 && !hold_credit) begin
      rob_credit = 1'b1;
      pending_credits--;
    end else begin
      rob_credit = 1'b0;
    end
  end

  function automatic vreg_t rand_vreg();
    vreg_t r;
    for (int k = 0; k < VLEN / 32; k++) begin
      r[k*32 +: 32] = $urandom();
    end
    return r;
  endfunction

  function automatic logic logic_bit(mask_op_e op, logic a, logic b);
    case (op)
      MOP_AND:  return a & b;
      MOP_NAND: return !(a & b);
      MOP_ANDN: return a & !b;
      MOP_XOR:  return a ^ b;
      MOP_OR:   return a | b;
      MOP_NOR:  return !(a | b);
      MOP_ORN:  return a | !b;
      MOP_XNOR: return !(a ^ b);
      default:  return 1'b0;
    endcase
  endfunction

  // vs2 with the tail cleared and, if vm is 0, masked by v0
  function automatic vreg_t masked_source(logic m, vl_t l, vreg_t v0, vreg_t a2);
    vreg_t s;
    for (int i = 0; i < VLEN; i++) begin
      s[i] = ((i < l) && (m || v0[i])) ? a2[i] : 1'b0;
    end
    return s;
  endfunction

  function automatic vreg_t model(mask_op_e op, logic m, vl_t vs, vl_t l,
                                  vreg_t v0, vreg_t vd, vreg_t a1, vreg_t a2);
    vreg_t src;
    vreg_t res;
    int    first;
    int    cnt;
    src   = masked_source(m, l, v0, a2);
    first = -1;
    cnt   = 0;
    for (int i = VLEN - 1; i >= 0; i--) begin
      if (src[i]) begin
        first = i;
        cnt++;
      end
    end
    res = '0;
    case (op)
      MOP_CPOP:  res = VLEN'(cnt);
      MOP_FIRST: res = (first < 0) ? '1 : VLEN'(first);
      MOP_SBF, MOP_SIF, MOP_SOF: begin
        for (int i = 0; i < VLEN; i++) begin
          if (first < 0) begin
            res[i] = 1'b1;
          end else if (op == MOP_SBF) begin
            res[i] = i < first;
          end else if (op == MOP_SIF) begin
            res[i] = i <= first;
          end else begin
            res[i] = i == first;
          end
          if (!m && (i < l) && !v0[i]) begin
            res[i] = vd[i];
          end
        end
      end
      default: begin
        for (int i = 0; i < VLEN; i++) begin
          res[i] = (i < vs) ? vd[i] : logic_bit(op, a2[i], a1[i]);
        end
      end
    endcase
    return res;
  endfunction

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_uop(mask_op_e op, logic m, vl_t vs, vl_t l,
                           vreg_t v0, vreg_t vd, vreg_t a1, vreg_t a2);
    int waited;
    waited = 0;
    funct3 = OPMVV;
    vs1_op = '0;
    case (op)
      MOP_AND:  funct6 = VMAND;
      MOP_NAND: funct6 = VMNAND;
      MOP_ANDN: funct6 = VMANDN;
      MOP_XOR:  funct6 = VMXOR;
      MOP_OR:   funct6 = VMOR;
      MOP_NOR:  funct6 = VMNOR;
      MOP_ORN:  funct6 = VMORN;
      MOP_XNOR: funct6 = VMXNOR;
      MOP_CPOP, MOP_FIRST: begin
        funct6 = VWXUNARY0;
        vs1_op = (op == MOP_CPOP) ? VCPOP : VFIRST;
      end
      MOP_SBF, MOP_SIF, MOP_SOF: begin
        funct6 = VMUNARY0;
        vs1_op = (op == MOP_SBF) ? VMSBF : (op == MOP_SIF) ? VMSIF : VMSOF;
      end
      default: funct6 = '0;
    endcase
    rob_entry = next_rob;
    vm        = m;
    vstart    = vs;
    vl        = l;
    v0_data   = v0;
    vd_data   = vd;
    vs1_data  = a1;
    vs2_data  = a2;
    uop_valid = 1'b1;
    while (!uop_ready) begin
      if (waited >= READY_TIMEOUT) begin
        errors++;
        $display("at %0t ns uop_ready stayed low for %0d cycles", $time, READY_TIMEOUT);
        uop_valid = 1'b0;
        return;
      end
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    exp_data_q.push_back(model(op, m, vs, l, v0, vd, a1, a2));
    exp_rob_q.push_back(next_rob);
    next_rob++;
    @(negedge clk);
  endtask

  task automatic issue_random(mask_op_e op, logic m);
    issue_uop(op, m, vl_t'($urandom_range(0, VLEN - 1)), vl_t'($urandom_range(0, VLEN)),
              rand_vreg(), rand_vreg(), rand_vreg(), rand_vreg());
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    uop_valid = 1'b0;
    while (exp_data_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      errors++;
      $display("at %0t ns %0d results never arrived", $time, exp_data_q.size());
      exp_data_q.delete();
      exp_rob_q.delete();
    end
    @(negedge clk);
  endtask

  task automatic finish_test(string name, int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = errors;
    compare("result_valid", VLEN'(0), VLEN'(result_valid));
    compare("uop_ready", VLEN'(1), VLEN'(uop_ready));
    finish_test("reset", errs);
  endtask

  task automatic test_logical();
    int errs;
    errs = errors;
    for (int op = int'(MOP_AND); op <= int'(MOP_XNOR); op++) begin
      issue_random(mask_op_e'(op), logic'($urandom_range(0, 1)));
    end
    drain();
    finish_test("logical", errs);
  endtask

  task automatic test_count_first();
    int       errs;
    mask_op_e op;
    errs = errors;
    for (int k = 0; k < 2; k++) begin
      op = (k == 0) ? MOP_CPOP : MOP_FIRST;
      issue_random(op, 1'b1);
      issue_random(op, 1'b0);
      // empty source
      issue_uop(op, 1'b0, '0, vl_t'(VLEN), rand_vreg(), rand_vreg(), rand_vreg(), '0);
    end
    drain();
    finish_test("vcpop_vfirst", errs);
  endtask

  task automatic test_set_first();
    int errs;
    errs = errors;
    for (int op = int'(MOP_SBF); op <= int'(MOP_SOF); op++) begin
      issue_random(mask_op_e'(op), 1'b1);
      issue_random(mask_op_e'(op), 1'b0);
      issue_uop(mask_op_e'(op), 1'b0, '0, vl_t'($urandom_range(0, VLEN)),
                rand_vreg(), rand_vreg(), rand_vreg(), '0);
    end
    drain();
    finish_test("vmsbf_vmsif_vmsof", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    int accepted;
    int idle;
    int rcv_start;
    errs      = errors;
    accepted  = 0;
    idle      = 0;
    rcv_start = received;
    @(posedge clk);
    hold_credit = 1'b1;
    @(negedge clk);
    while (idle < BP_IDLE_LIMIT && accepted < 2 * (ROB_CREDITS + FIFO_DEPTH)) begin
      if (uop_ready) begin
        issue_random(mask_op_e'($urandom_range(int'(MOP_AND), int'(MOP_SOF))),
                     logic'($urandom_range(0, 1)));
        accepted++;
        idle = 0;
      end else begin
        uop_valid = 1'b0;
        idle++;
        @(negedge clk);
      end
    end
    compare("accepted uops", VLEN'(ROB_CREDITS + FIFO_DEPTH), VLEN'(accepted));
    compare("uop_ready", VLEN'(0), VLEN'(uop_ready));
    @(posedge clk);
    hold_credit = 1'b0;
    drain();
    compare("results received", VLEN'(accepted), VLEN'(received - rcv_start));
    finish_test("backpressure", errs);
  endtask

  task automatic test_streaming();
    int errs;
    errs = errors;
    for (int k = 0; k < 20; k++) begin
      issue_random(mask_op_e'($urandom_range(int'(MOP_AND), int'(MOP_SOF))),
                   logic'($urandom_range(0, 1)));
    end
    drain();
    finish_test("streaming", errs);
  endtask

  initial begin
    void'($urandom(32'h15cb));
    rst_n     = 1'b0;
    uop_valid = 1'b0;
    rob_entry = '0;
    funct3    = '0;
    funct6    = '0;
    vs1_op    = '0;
    vm        = 1'b1;
    vstart    = '0;
    vl        = '0;
    v0_data   = '0;
    vd_data   = '0;
    vs1_data  = '0;
    vs2_data  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset();
    test_logical();
    test_count_first();
    test_set_first();
    test_backpressure();
    test_streaming();

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== mask_alu_top.f ====
common/mask_cfg_pkg.sv
common/mask_op_pkg.sv
exec/mask_find_first.sv
exec/mask_popcount.sv
src/mask_issue.sv
src/mask_result_fifo.sv
src/mask_rob_sender.sv
src/mask_alu_top.sv
tests/tb_mask_alu.sv

// ==== Bender.yml ====
package:
  name: mask_alu

sources:
  - common/mask_cfg_pkg.sv
  - common/mask_op_pkg.sv
  - exec/mask_find_first.sv
  - exec/mask_popcount.sv
  - src/mask_issue.sv
  - src/mask_result_fifo.sv
  - src/mask_rob_sender.sv
  - src/mask_alu_top.sv
  - target: test
    files:
      - tests/tb_mask_alu.sv
